// ==== list.f ====
+incdir+src
src/rv32_isa_pkg.sv
src/core_ctrl_pkg.sv
src/fetch_unit.sv
src/decode.sv
src/execute_unit.sv
src/mem_arbiter.sv
src/core_top.sv
verif/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module core_tb -f list.f -o core_tb_sim
./obj_dir/core_tb_sim 2>&1 | tee sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== src/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

typedef logic [1:0] credit_t;

// who is waiting on next cycle's read data
typedef enum logic [1:0] {
	OWN_NONE,
	OWN_FETCH,
	OWN_DATA
} mem_owner_t;

typedef enum logic {
	FS_RUN,
	FS_WAIT_RESP
} fetch_state_t;

typedef enum logic {
	ES_IDLE,
	ES_MEM_WAIT
} exe_state_t;

endpackage : core_ctrl_pkg

// ==== src/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`define DEC_CREDITS 1 // decode input slot depth
`define EXE_CREDITS 2 // execute queue depth

`define NUM_REGS 32

`endif

// ==== src/core_top.sv ====
module core_top import rv32_isa_pkg::*;
(
	input logic clk,
	input logic rst_n,
	output logic mem_req,
	output logic mem_we,
	output word_t mem_addr,
	output word_t mem_wdata,
	input word_t mem_rdata,
	output logic retire_valid,
	output word_t retire_pc,
	output word_t retire_value,
	output reg_idx_t retire_rd
);

logic fd_valid, fd_credit;
word_t fd_pc, fd_instr;
logic de_valid, de_credit;
instr_kind_t de_kind;
alu_op_t de_alu_op;
word_t de_a, de_b, de_imm, de_pc;
reg_idx_t de_rd;
logic wb_valid;
reg_idx_t wb_rd;
word_t wb_data;
logic redirect_valid;
word_t redirect_pc;
logic if_req, if_gnt, if_rvalid;
word_t if_addr, if_rdata;
logic ex_req, ex_we, ex_gnt, ex_rvalid;
word_t ex_addr, ex_wdata, ex_rdata;

fetch_unit fetch_i (
	.clk, .rst_n, .fd_credit, .redirect_valid, .redirect_pc,
	.if_gnt, .if_rvalid, .if_rdata,
	.fd_valid, .fd_pc, .fd_instr, .if_req, .if_addr
);

decode decode_i (
	.clk, .rst_n, .fd_valid, .fd_pc, .fd_instr, .de_credit,
	.wb_valid, .wb_rd, .wb_data, .redirect_valid,
	.fd_credit, .de_valid, .de_kind, .de_alu_op,
	.de_a, .de_b, .de_imm, .de_pc, .de_rd
);

execute_unit execute_i (
	.clk, .rst_n, .de_valid, .de_kind, .de_alu_op, .de_a, .de_b, .de_imm,
	.de_rd, .de_pc, .ex_gnt, .ex_rvalid, .ex_rdata,
	.de_credit, .wb_valid, .wb_rd, .wb_data, .redirect_valid, .redirect_pc,
	.ex_req, .ex_we, .ex_addr, .ex_wdata,
	.retire_valid, .retire_pc, .retire_value, .retire_rd
);

mem_arbiter arbiter_i (
	.clk, .rst_n, .if_req, .if_addr, .ex_req, .ex_we, .ex_addr, .ex_wdata,
	.mem_rdata, .if_gnt, .if_rvalid, .if_rdata, .ex_gnt, .ex_rvalid, .ex_rdata,
	.mem_req, .mem_we, .mem_addr, .mem_wdata
);

endmodule : core_top

// ==== src/decode.sv ====
`include "core_macros.svh"

module decode import rv32_isa_pkg::*, core_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic fd_valid,
	input word_t fd_pc,
	input word_t fd_instr,
	input logic de_credit,
	input logic wb_valid,
	input reg_idx_t wb_rd,
	input word_t wb_data,
	input logic redirect_valid,
	output logic fd_credit,
	output logic de_valid,
	output instr_kind_t de_kind,
	output alu_op_t de_alu_op,
	output word_t de_a,
	output word_t de_b,
	output word_t de_imm,
	output word_t de_pc,
	output reg_idx_t de_rd
);

logic slot_valid;
word_t slot_pc;
word_t slot_instr;
logic branch_pending; // wrong-path words dropped until redirect
credit_t exe_credits;
logic [`NUM_REGS-1:0] busy; // scoreboard, one bit per register
word_t regs [`NUM_REGS];

opcode_t opcode;
logic [2:0] funct3;
logic [6:0] funct7;
reg_idx_t rs1;
reg_idx_t rs2;
reg_idx_t rd;
word_t imm_i, imm_s, imm_b, imm_u, imm_j;
word_t rs1_val;
word_t rs2_val;
logic use_rs1, use_rs2, use_imm, writes_rd;
logic rs1_busy, rs2_busy, rd_busy;
logic issue;
logic drop;

assign opcode = opcode_t'(slot_instr[6:0]);
assign funct3 = slot_instr[14:12];
assign funct7 = slot_instr[31:25];
assign rs1 = slot_instr[19:15];
assign rs2 = slot_instr[24:20];
assign rd = slot_instr[11:7];

assign imm_i = {{20{slot_instr[31]}}, slot_instr[31:20]};
assign imm_s = {{20{slot_instr[31]}}, slot_instr[31:25], slot_instr[11:7]};
assign imm_b = {{19{slot_instr[31]}}, slot_instr[31], slot_instr[7],
	slot_instr[30:25], slot_instr[11:8], 1'b0};
assign imm_u = {slot_instr[31:12], 12'b0};
assign imm_j = {{11{slot_instr[31]}}, slot_instr[31], slot_instr[19:12],
	slot_instr[20], slot_instr[30:21], 1'b0};

always_comb begin
	de_kind = KIND_ALU;
	de_alu_op = ALU_ADD;
	de_imm = imm_i;
	use_rs1 = 1'b1;
	use_rs2 = 1'b0;
	use_imm = 1'b1;
	writes_rd = 1'b1;
	case (opcode)
		OP_LUI: begin
			de_alu_op = ALU_PASS_B;
			de_imm = imm_u;
			use_rs1 = 1'b0;
		end
		OP_IMM, OP_REG: begin
			use_imm = (opcode == OP_IMM);
			use_rs2 = (opcode == OP_REG);
			case (funct3)
				F3_ADD: de_alu_op = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
				F3_SLT: de_alu_op = ALU_SLT;
				F3_XOR: de_alu_op = ALU_XOR;
				F3_OR: de_alu_op = ALU_OR;
				F3_AND: de_alu_op = ALU_AND;
				default: de_alu_op = ALU_ADD;
			endcase
		end
		OP_LOAD: de_kind = KIND_LOAD;
		OP_STORE: begin
			de_kind = KIND_STORE;
			de_imm = imm_s;
			use_rs2 = 1'b1; // store data rides on de_b
			use_imm = 1'b0;
			writes_rd = 1'b0;
		end
		OP_BRANCH: begin
			de_kind = KIND_BRANCH;
			de_alu_op = (funct3 == F3_BNE) ? ALU_XOR : ALU_SUB;
			de_imm = imm_b;
			use_rs2 = 1'b1;
			use_imm = 1'b0;
			writes_rd = 1'b0;
		end
		OP_JAL: begin
			de_kind = KIND_JAL;
			de_imm = imm_j;
			use_rs1 = 1'b0;
		end
		default: writes_rd = 1'b0; // outside the subset, retires as a nop
	endcase
end

// register read with write-back bypass
always_comb begin
	rs1_val = regs[rs1];
	if (rs1 == '0)
		rs1_val = '0;
	else if (wb_valid && wb_rd == rs1)
		rs1_val = wb_data;
	rs2_val = regs[rs2];
	if (rs2 == '0)
		rs2_val = '0;
	else if (wb_valid && wb_rd == rs2)
		rs2_val = wb_data;
end

// a bit being cleared this cycle no longer blocks
assign rs1_busy = use_rs1 && busy[rs1] && !(wb_valid && wb_rd == rs1);
assign rs2_busy = use_rs2 && busy[rs2] && !(wb_valid && wb_rd == rs2);
assign rd_busy = writes_rd && busy[rd] && !(wb_valid && wb_rd == rd);

assign issue = slot_valid && !branch_pending && (exe_credits != '0) &&
	!rs1_busy && !rs2_busy && !rd_busy;
assign drop = fd_valid && branch_pending;
assign fd_credit = issue || drop;

assign de_valid = issue;
assign de_a = rs1_val;
assign de_b = use_imm ? de_imm : rs2_val;
assign de_pc = slot_pc;
assign de_rd = writes_rd ? rd : '0;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		slot_valid <= 1'b0;
		branch_pending <= 1'b0;
		exe_credits <= credit_t'(`EXE_CREDITS);
		busy <= '0;
	end else begin
		exe_credits <= exe_credits - credit_t'(issue) + credit_t'(de_credit);
		if (fd_valid && !branch_pending)
			slot_valid <= 1'b1;
		else if (issue)
			slot_valid <= 1'b0;
		if (redirect_valid)
			branch_pending <= 1'b0;
		else if (issue && (de_kind == KIND_BRANCH || de_kind == KIND_JAL))
			branch_pending <= 1'b1;
		for (int r = 1; r < `NUM_REGS; r++) begin // x0 never busy
			if (issue && writes_rd && rd == reg_idx_t'(r))
				busy[r] <= 1'b1;
			else if (wb_valid && wb_rd == reg_idx_t'(r))
				busy[r] <= 1'b0;
		end
	end
end

always_ff @(posedge clk) begin
	if (fd_valid && !branch_pending) begin
		slot_pc <= fd_pc;
		slot_instr <= fd_instr;
	end
	if (wb_valid && wb_rd != '0)
		regs[wb_rd] <= wb_data;
end

endmodule : decode

// ==== src/execute_unit.sv ====
`include "core_macros.svh"

module execute_unit import rv32_isa_pkg::*, core_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic de_valid,
	input instr_kind_t de_kind,
	input alu_op_t de_alu_op,
	input word_t de_a,
	input word_t de_b,
	input word_t de_imm,
	input reg_idx_t de_rd,
	input word_t de_pc,
	input logic ex_gnt,
	input logic ex_rvalid,
	input word_t ex_rdata,
	output logic de_credit,
	output logic wb_valid,
	output reg_idx_t wb_rd,
	output word_t wb_data,
	output logic redirect_valid,
	output word_t redirect_pc,
	output logic ex_req,
	output logic ex_we,
	output word_t ex_addr,
	output word_t ex_wdata,
	output logic retire_valid,
	output word_t retire_pc,
	output word_t retire_value,
	output reg_idx_t retire_rd
);

localparam int PTR_W = $clog2(`EXE_CREDITS);

instr_kind_t q_kind [`EXE_CREDITS];
alu_op_t q_op [`EXE_CREDITS];
word_t q_a [`EXE_CREDITS];
word_t q_b [`EXE_CREDITS];
word_t q_imm [`EXE_CREDITS];
word_t q_pc [`EXE_CREDITS];
reg_idx_t q_rd [`EXE_CREDITS];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
credit_t q_count;
exe_state_t state;
logic head_seen; // head has sat one cycle
logic head_valid, is_mem, is_flow, taken, retire;
word_t alu_out;
word_t result;

assign head_valid = (q_count != '0);
assign is_mem = (q_kind[rd_ptr] == KIND_LOAD) || (q_kind[rd_ptr] == KIND_STORE);
assign is_flow = (q_kind[rd_ptr] == KIND_BRANCH) || (q_kind[rd_ptr] == KIND_JAL);

always_comb begin
	case (q_op[rd_ptr])
		ALU_ADD: alu_out = q_a[rd_ptr] + q_b[rd_ptr];
		ALU_SUB: alu_out = q_a[rd_ptr] - q_b[rd_ptr];
		ALU_AND: alu_out = q_a[rd_ptr] & q_b[rd_ptr];
		ALU_OR: alu_out = q_a[rd_ptr] | q_b[rd_ptr];
		ALU_XOR: alu_out = q_a[rd_ptr] ^ q_b[rd_ptr];
		ALU_SLT: alu_out = {31'b0, $signed(q_a[rd_ptr]) < $signed(q_b[rd_ptr])};
		default: alu_out = q_b[rd_ptr]; // lui
	endcase
end

// sub marks beq, xor marks bne
assign taken = (q_kind[rd_ptr] == KIND_JAL) ||
	((q_op[rd_ptr] == ALU_SUB) ? (q_a[rd_ptr] == q_b[rd_ptr]) : (q_a[rd_ptr] != q_b[rd_ptr]));

assign ex_req = head_valid && is_mem && (state == ES_IDLE);
assign ex_we = (q_kind[rd_ptr] == KIND_STORE);
assign ex_addr = q_a[rd_ptr] + q_imm[rd_ptr];
assign ex_wdata = q_b[rd_ptr];

assign retire = (head_valid && !is_mem && head_seen) ||
	(ex_req && ex_gnt && ex_we) ||
	((state == ES_MEM_WAIT) && ex_rvalid);

always_comb begin
	case (q_kind[rd_ptr])
		KIND_ALU: result = alu_out;
		KIND_JAL: result = q_pc[rd_ptr] + 32'd4; // link
		KIND_LOAD: result = ex_rdata;
		default: result = '0;
	endcase
	if (q_rd[rd_ptr] == '0)
		result = '0;
end

assign de_credit = retire;
assign wb_valid = retire;
assign wb_rd = q_rd[rd_ptr];
assign wb_data = result;
assign retire_valid = retire;
assign retire_pc = q_pc[rd_ptr];
assign retire_value = result;
assign retire_rd = q_rd[rd_ptr];
assign redirect_valid = retire && is_flow;
assign redirect_pc = taken ? q_pc[rd_ptr] + q_imm[rd_ptr] : q_pc[rd_ptr] + 32'd4;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		q_count <= '0;
		state <= ES_IDLE;
		head_seen <= 1'b0;
	end else begin
		q_count <= q_count + credit_t'(de_valid) - credit_t'(retire);
		if (de_valid)
			wr_ptr <= wr_ptr + 1'b1;
		if (retire)
			rd_ptr <= rd_ptr + 1'b1;
		head_seen <= head_valid && !retire;
		case (state)
			ES_IDLE: begin
				if (ex_req && ex_gnt && !ex_we)
					state <= ES_MEM_WAIT;
			end
			ES_MEM_WAIT: begin
				if (ex_rvalid)
					state <= ES_IDLE;
			end
			default: state <= ES_IDLE;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (de_valid) begin
		q_kind[wr_ptr] <= de_kind;
		q_op[wr_ptr] <= de_alu_op;
		q_a[wr_ptr] <= de_a;
		q_b[wr_ptr] <= de_b;
		q_imm[wr_ptr] <= de_imm;
		q_pc[wr_ptr] <= de_pc;
		q_rd[wr_ptr] <= de_rd;
	end
end

endmodule : execute_unit

// ==== src/fetch_unit.sv ====
`include "core_macros.svh"

module fetch_unit import rv32_isa_pkg::*, core_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic fd_credit,
	input logic redirect_valid,
	input word_t redirect_pc,
	input logic if_gnt,
	input logic if_rvalid,
	input word_t if_rdata,
	output logic fd_valid,
	output word_t fd_pc,
	output word_t fd_instr,
	output logic if_req,
	output word_t if_addr
);

fetch_state_t state;
word_t pc;
credit_t credits;
logic epoch;
logic req_epoch; // epoch of the request in flight
logic resp_ok;

// the word in fd_valid still owns its credit until this edge
assign if_req = (state == FS_RUN) && (credits != '0) && !fd_valid;
assign if_addr = pc;

// response from the current path and no redirect landing now
assign resp_ok = if_rvalid && (req_epoch == epoch) && !redirect_valid;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= FS_RUN;
		pc <= `RESET_PC;
		credits <= credit_t'(`DEC_CREDITS);
		epoch <= 1'b0;
		req_epoch <= 1'b0;
		fd_valid <= 1'b0;
	end else begin
		credits <= credits - credit_t'(fd_valid) + credit_t'(fd_credit);
		epoch <= epoch ^ redirect_valid;
		fd_valid <= resp_ok;
		case (state)
			FS_RUN: begin
				if (if_req && if_gnt) begin // lost grant just retries
					state <= FS_WAIT_RESP;
					req_epoch <= epoch;
				end
			end
			FS_WAIT_RESP: begin
				if (if_rvalid)
					state <= FS_RUN;
			end
			default: state <= FS_RUN;
		endcase
		if (redirect_valid)
			pc <= redirect_pc;
		else if (resp_ok)
			pc <= pc + 32'd4;
	end
end

always_ff @(posedge clk) begin
	if (resp_ok) begin
		fd_pc <= pc; // pc still holds the requested address
		fd_instr <= if_rdata;
	end
end

endmodule : fetch_unit

// ==== src/mem_arbiter.sv ====
module mem_arbiter import rv32_isa_pkg::*, core_ctrl_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic if_req,
	input word_t if_addr,
	input logic ex_req,
	input logic ex_we,
	input word_t ex_addr,
	input word_t ex_wdata,
	input word_t mem_rdata,
	output logic if_gnt,
	output logic if_rvalid,
	output word_t if_rdata,
	output logic ex_gnt,
	output logic ex_rvalid,
	output word_t ex_rdata,
	output logic mem_req,
	output logic mem_we,
	output word_t mem_addr,
	output word_t mem_wdata
);

mem_owner_t owner; // owner of the read issued last cycle
mem_owner_t owner_next;

// data side always wins
assign ex_gnt = ex_req;
assign if_gnt = if_req && !ex_req;

assign mem_req = if_req || ex_req;
assign mem_we = ex_req && ex_we;
assign mem_addr = ex_req ? ex_addr : if_addr;
assign mem_wdata = ex_wdata;

always_comb begin
	owner_next = OWN_NONE;
	if (ex_gnt && !ex_we)
		owner_next = OWN_DATA;
	else if (if_gnt)
		owner_next = OWN_FETCH;
end

assign if_rvalid = (owner == OWN_FETCH);
assign if_rdata = if_rvalid ? mem_rdata : '0;
assign ex_rvalid = (owner == OWN_DATA);
assign ex_rdata = ex_rvalid ? mem_rdata : '0;

always_ff @(posedge clk) begin
	if (!rst_n)
		owner <= OWN_NONE;
	else
		owner <= owner_next;
end

endmodule : mem_arbiter

// ==== src/rv32_isa_pkg.sv ====
package rv32_isa_pkg;

typedef logic [31:0] word_t;
typedef logic [4:0] reg_idx_t;

// major opcodes of the supported subset
typedef enum logic [6:0] {
	OP_LUI    = 7'b0110111,
	OP_JAL    = 7'b1101111,
	OP_BRANCH = 7'b1100011,
	OP_LOAD   = 7'b0000011,
	OP_STORE  = 7'b0100011,
	OP_IMM    = 7'b0010011,
	OP_REG    = 7'b0110011
} opcode_t;

// funct3 values for ALU ops and branches
localparam logic [2:0] F3_ADD = 3'b000; // also sub with funct7[5]
localparam logic [2:0] F3_SLT = 3'b010;
localparam logic [2:0] F3_XOR = 3'b100;
localparam logic [2:0] F3_OR  = 3'b110;
localparam logic [2:0] F3_AND = 3'b111;
localparam logic [2:0] F3_BNE = 3'b001;

// branches reuse the op field: sub means beq, xor means bne
typedef enum logic [2:0] {
	ALU_ADD,
	ALU_SUB,
	ALU_AND,
	ALU_OR,
	ALU_XOR,
	ALU_SLT,
	ALU_PASS_B
} alu_op_t;

typedef enum logic [2:0] {
	KIND_ALU,
	KIND_LOAD,
	KIND_STORE,
	KIND_BRANCH,
	KIND_JAL
} instr_kind_t;

endpackage : rv32_isa_pkg

// ==== verif/core_tb.sv ====
`include "core_macros.svh"

module core_tb import rv32_isa_pkg::*;
();

localparam int MEM_WORDS = 1024;
localparam int TIMEOUT_CYCLES = 20000;

logic clk;
logic rst_n;
logic mem_req;
logic mem_we;
word_t mem_addr;
word_t mem_wdata;
word_t mem_rdata = '0;
logic retire_valid;
word_t retire_pc;
word_t retire_value;
reg_idx_t retire_rd;

word_t mem [MEM_WORDS];
word_t ref_mem [MEM_WORDS];
word_t prog [$];
word_t exp_pc [$];
reg_idx_t exp_rd [$];
word_t exp_val [$];
word_t exp_addr [$];
word_t exp_data [$];
word_t exp_ld_addr [$]; // load addresses in program order
logic load_img;
logic checking;
logic load_pending = 1'b0;
logic rd_pending = 1'b0;
logic wr_pending = 1'b0;
word_t rd_addr = '0;
word_t wr_addr = '0;
word_t wr_data = '0;
int conflicts = 0; // cycles where both peers wanted the bus
logic [31:0] seed_ret;

core_top dut_i (
	.clk, .rst_n, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata,
	.retire_valid, .retire_pc, .retire_value, .retire_rd
);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

function automatic word_t fill_word(input int i);
	return (word_t'(i) * 32'h9e37_79b1) ^ 32'h0bad_f00d;
endfunction

function automatic word_t enc_i(input opcode_t op, input logic [2:0] f3, input reg_idx_t rd,
	input reg_idx_t rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_r(input logic [2:0] f3, input logic sub, input reg_idx_t rd,
	input reg_idx_t rs1, input reg_idx_t rs2);
	return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic word_t enc_sw(input reg_idx_t rs2, input reg_idx_t rs1,
	input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
endfunction

function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
	input logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic word_t enc_lui(input reg_idx_t rd, input logic [19:0] imm);
	return {imm, rd, OP_LUI};
endfunction

function automatic word_t enc_jal(input reg_idx_t rd, input logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

// instruction-set model, builds the expected retire and store lists
function automatic void ref_run();
	word_t x [`NUM_REGS];
	word_t pc;
	word_t ins;
	word_t a;
	word_t b;
	word_t res;
	word_t addr;
	word_t next_pc;
	word_t imm_i, imm_s, imm_b, imm_j;
	reg_idx_t rd;
	logic writes;
	exp_pc.delete();
	exp_rd.delete();
	exp_val.delete();
	exp_addr.delete();
	exp_data.delete();
	exp_ld_addr.delete();
	for (int i = 0; i < MEM_WORDS; i++)
		ref_mem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
	for (int r = 0; r < `NUM_REGS; r++)
		x[r] = '0;
	pc = `RESET_PC;
	for (int steps = 0; steps < 5000; steps++) begin
		ins = ref_mem[pc[11:2]];
		a = x[ins[19:15]];
		b = x[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		rd = ins[11:7];
		writes = 1'b1;
		res = '0;
		next_pc = pc + 4;
		case (opcode_t'(ins[6:0]))
			OP_LUI: res = {ins[31:12], 12'b0};
			OP_IMM, OP_REG: begin
				if (ins[6:0] == OP_IMM)
					b = imm_i;
				case (ins[14:12])
					3'b010: res = {31'b0, $signed(a) < $signed(b)};
					3'b100: res = a ^ b;
					3'b110: res = a | b;
					3'b111: res = a & b;
					default: res = (ins[6:0] == OP_REG && ins[30]) ? a - b : a + b;
				endcase
			end
			OP_LOAD: begin
				addr = a + imm_i;
				res = ref_mem[addr[11:2]];
				exp_ld_addr.push_back(addr);
			end
			OP_STORE: begin
				addr = a + imm_s;
				ref_mem[addr[11:2]] = b;
				exp_addr.push_back(addr);
				exp_data.push_back(b);
				writes = 1'b0;
			end
			OP_BRANCH: begin
				writes = 1'b0;
				if ((ins[14:12] == 3'b001) ? (a != b) : (a == b))
					next_pc = pc + imm_b;
			end
			OP_JAL: begin
				res = pc + 4; // link
				next_pc = pc + imm_j;
			end
			default: writes = 1'b0;
		endcase
		if (!writes)
			rd = '0;
		if (rd == '0)
			res = '0;
		else
			x[rd] = res;
		exp_pc.push_back(pc);
		exp_rd.push_back(rd);
		exp_val.push_back(res);
		if (next_pc == pc)
			break; // self-jump ends the program
		pc = next_pc;
	end
endfunction

task automatic abort_run();
	$display("TB FAILED");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_retire(input word_t pc, input reg_idx_t rd, input word_t value);
	word_t e_pc;
	reg_idx_t e_rd;
	word_t e_val;
	e_pc = exp_pc.pop_front();
	e_rd = exp_rd.pop_front();
	e_val = exp_val.pop_front();
	if (pc !== e_pc)
		$display("CHECK FAILED retire_pc got %h expected %h", pc, e_pc);
	if (rd !== e_rd)
		$display("CHECK FAILED retire_rd got %h expected %h at pc %h", rd, e_rd, e_pc);
	if (value !== e_val)
		$display("CHECK FAILED retire_value got %h expected %h at pc %h", value, e_val, e_pc);
	if (pc !== e_pc || rd !== e_rd || value !== e_val)
		abort_run();
endtask

task automatic check_store(input word_t addr, input word_t data);
	word_t e_addr;
	word_t e_data;
	if (exp_addr.size() == 0) begin
		$display("a store to address %h appeared on the memory bus but none was expected", addr);
		abort_run();
	end else begin
		e_addr = exp_addr.pop_front();
		e_data = exp_data.pop_front();
		if (addr !== e_addr)
			$display("CHECK FAILED mem_addr got %h expected %h", addr, e_addr);
		if (data !== e_data)
			$display("CHECK FAILED mem_wdata got %h expected %h", data, e_data);
		if (addr !== e_addr || data !== e_data)
			abort_run();
	end
endtask

// data request present, so fetch must be locked out and a load carries its own address
task automatic check_data_access(input logic if_gnt, input logic we, input word_t addr);
	word_t e_addr;
	if (if_gnt !== 1'b0) begin
		$display("CHECK FAILED if_gnt got %h expected %h", if_gnt, 1'b0);
		abort_run();
	end else if (!we) begin
		if (exp_ld_addr.size() == 0) begin
			$display("unexpected load read at address %h on the memory bus", addr);
			abort_run();
		end else begin
			e_addr = exp_ld_addr.pop_front();
			if (addr !== e_addr) begin
				$display("CHECK FAILED mem_addr got %h expected %h", addr, e_addr);
				abort_run();
			end
		end
	end
endtask

// memory model, bus sampled mid-cycle
always @(negedge clk) begin
	rd_pending <= mem_req && !mem_we;
	rd_addr <= mem_addr;
	wr_pending <= mem_req && mem_we && rst_n;
	wr_addr <= mem_addr;
	wr_data <= mem_wdata;
	load_pending <= load_img;
end

always @(posedge clk) begin
	#1;
	if (load_pending) begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
	end else if (wr_pending) begin
		mem[wr_addr[11:2]] = wr_data;
	end
	mem_rdata = rd_pending ? mem[rd_addr[11:2]] : '0; // one cycle after the request
end

always @(negedge clk) begin
	if (checking) begin
		if (retire_valid && exp_pc.size() != 0)
			check_retire(retire_pc, retire_rd, retire_value);
		if (mem_req && mem_we)
			check_store(mem_addr, mem_wdata);
		if (dut_i.ex_req) begin
			check_data_access(dut_i.if_gnt, mem_we, mem_addr);
			if (dut_i.if_req)
				conflicts <= conflicts + 1;
		end
	end
end

function automatic logic [2:0] pick_f3();
	case ($urandom_range(4, 0))
		0: return F3_ADD;
		1: return F3_SLT;
		2: return F3_XOR;
		3: return F3_OR;
		default: return F3_AND;
	endcase
endfunction

task automatic build_alu();
	prog.delete();
	prog.push_back(enc_lui(5'd1, 20'h12345));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'hffb)); // -5
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd3, 5'd1, 12'h678));
	prog.push_back(enc_i(OP_IMM, F3_AND, 5'd4, 5'd3, 12'h0f0));
	prog.push_back(enc_i(OP_IMM, F3_OR, 5'd5, 5'd2, 12'h100));
	prog.push_back(enc_i(OP_IMM, F3_XOR, 5'd6, 5'd3, 12'hfff));
	prog.push_back(enc_i(OP_IMM, F3_SLT, 5'd7, 5'd2, 12'd3));
	prog.push_back(enc_i(OP_IMM, F3_SLT, 5'd8, 5'd3, 12'hfff));
	prog.push_back(enc_r(F3_ADD, 1'b0, 5'd9, 5'd3, 5'd2));
	prog.push_back(enc_r(F3_ADD, 1'b1, 5'd10, 5'd2, 5'd3));
	prog.push_back(enc_r(F3_AND, 1'b0, 5'd11, 5'd3, 5'd6));
	prog.push_back(enc_r(F3_OR, 1'b0, 5'd12, 5'd4, 5'd5));
	prog.push_back(enc_r(F3_XOR, 1'b0, 5'd13, 5'd9, 5'd10));
	prog.push_back(enc_r(F3_SLT, 1'b0, 5'd14, 5'd2, 5'd1));
	prog.push_back(enc_r(F3_SLT, 1'b0, 5'd15, 5'd1, 5'd2));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd16, 5'd16, 12'd1)); // dependent chain
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd16, 5'd16, 12'd1));
	prog.push_back(enc_r(F3_ADD, 1'b0, 5'd16, 5'd16, 5'd16));
	prog.push_back(enc_r(F3_ADD, 1'b1, 5'd17, 5'd16, 5'd13));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd0, 5'd1, 12'd5)); // x0 stays zero
	prog.push_back(enc_jal(5'd0, 21'd0));
endtask

task automatic build_mem();
	prog.delete();
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'h600));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'h123));
	prog.push_back(enc_sw(5'd2, 5'd1, 12'd0));
	prog.push_back(enc_i(OP_LOAD, 3'b010, 5'd3, 5'd1, 12'd0));
	prog.push_back(enc_sw(5'd3, 5'd1, 12'd4));
	prog.push_back(enc_i(OP_LOAD, 3'b010, 5'd4, 5'd1, 12'd8)); // untouched word
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd5, 5'd4, 12'd1));
	prog.push_back(enc_sw(5'd5, 5'd1, 12'd8));
	prog.push_back(enc_i(OP_LOAD, 3'b010, 5'd6, 5'd1, 12'd8));
	prog.push_back(enc_i(OP_LOAD, 3'b010, 5'd7, 5'd1, 12'd4));
	prog.push_back(enc_lui(5'd8, 20'habcde));
	prog.push_back(enc_sw(5'd8, 5'd1, 12'd12));
	prog.push_back(enc_i(OP_LOAD, 3'b010, 5'd9, 5'd1, 12'd12));
	prog.push_back(enc_r(F3_ADD, 1'b0, 5'd10, 5'd9, 5'd6));
	prog.push_back(enc_jal(5'd0, 21'd0));
endtask

task automatic build_branch();
	prog.delete();
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd5));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'd5));
	prog.push_back(enc_b(3'b000, 5'd1, 5'd2, 13'd8)); // taken
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd3, 5'd0, 12'd1));
	prog.push_back(enc_b(F3_BNE, 5'd1, 5'd2, 13'd8)); // not taken
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd4, 5'd0, 12'd2));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd2, 5'd2, 12'd1));
	prog.push_back(enc_b(3'b000, 5'd1, 5'd2, 13'd8)); // not taken
	prog.push_back(enc_b(F3_BNE, 5'd1, 5'd2, 13'd8)); // taken
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd5, 5'd0, 12'd3));
	prog.push_back(enc_jal(5'd6, 21'd8));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd7, 5'd0, 12'd4));
	prog.push_back(enc_r(F3_ADD, 1'b0, 5'd8, 5'd6, 5'd1));
	prog.push_back(enc_b(3'b000, 5'd0, 5'd0, 13'd8));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd9, 5'd0, 12'd9));
	prog.push_back(enc_jal(5'd0, 21'd0));
endtask

task automatic build_loop();
	int top;
	prog.delete();
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'h600));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'd6)); // trip count
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd3, 5'd0, 12'd0));
	top = prog.size() * 4;
	prog.push_back(enc_i(OP_LOAD, 3'b010, 5'd4, 5'd1, 12'd0));
	prog.push_back(enc_r(F3_ADD, 1'b0, 5'd3, 5'd3, 5'd4));
	prog.push_back(enc_sw(5'd3, 5'd1, 12'h040));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd1, 5'd1, 12'd4));
	prog.push_back(enc_i(OP_IMM, F3_ADD, 5'd2, 5'd2, 12'hfff));
	prog.push_back(enc_b(F3_BNE, 5'd2, 5'd0, 13'(top - prog.size() * 4)));
	prog.push_back(enc_sw(5'd3, 5'd0, 12'h7f0));
	prog.push_back(enc_i(OP_LOAD, 3'b010, 5'd10, 5'd0, 12'h640));
	prog.push_back(enc_jal(5'd0, 21'd0));
endtask

task automatic build_random(input int count);
	int kind;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic [2:0] f3;
	logic [11:0] addr_imm;
	prog.delete();
	for (int r = 1; r < 8; r++)
		prog.push_back(enc_i(OP_IMM, F3_ADD, reg_idx_t'(r), 5'd0, 12'($urandom)));
	for (int n = 0; n < count; n++) begin
		kind = int'($urandom_range(9, 0));
		rd = reg_idx_t'($urandom_range(7, 0)); // small pool keeps hazards frequent
		rs1 = reg_idx_t'($urandom_range(7, 0));
		rs2 = reg_idx_t'($urandom_range(7, 0));
		f3 = pick_f3();
		addr_imm = 12'(32'h600 + 4 * $urandom_range(63, 0));
		case (kind)
			0, 1, 2: prog.push_back(enc_i(OP_IMM, f3, rd, rs1, 12'($urandom)));
			3, 4, 5: prog.push_back(enc_r(f3, (f3 == F3_ADD) && ($urandom_range(1, 0) == 1),
				rd, rs1, rs2));
			6: prog.push_back(enc_lui(rd, 20'($urandom)));
			7: prog.push_back(enc_i(OP_LOAD, 3'b010, rd, 5'd0, addr_imm));
			default: prog.push_back(enc_sw(rs2, 5'd0, addr_imm));
		endcase
	end
	prog.push_back(enc_jal(5'd0, 21'd0));
endtask

task automatic run_program(input string name);
	int cycles;
	@(posedge clk);
	#1;
	rst_n = 1'b0;
	checking = 1'b0;
	load_img = 1'b1;
	ref_run();
	@(posedge clk);
	#1;
	load_img = 1'b0;
	repeat (3) @(posedge clk);
	#1;
	rst_n = 1'b1;
	checking = 1'b1;
	cycles = 0;
	while (exp_pc.size() != 0 && cycles < TIMEOUT_CYCLES) begin
		@(posedge clk);
		cycles++;
	end
	if (exp_pc.size() != 0) begin
		$display("%s program timed out with %0d retires still expected", name, exp_pc.size());
		abort_run();
	end else if (exp_addr.size() != 0) begin
		$display("%s program ended with %0d expected stores never seen", name, exp_addr.size());
		abort_run();
	end else if (exp_ld_addr.size() != 0) begin
		$display("%s program ended with %0d expected load reads never seen", name,
			exp_ld_addr.size());
		abort_run();
	end else begin
		$display("%s program done in %0d cycles", name, cycles);
	end
endtask

initial begin
	rst_n = 1'b0;
	load_img = 1'b0;
	checking = 1'b0;
	seed_ret = $urandom(32'hafdb);
	build_alu();
	run_program("alu");
	build_mem();
	run_program("load/store");
	build_branch();
	run_program("branch");
	build_loop();
	run_program("loop");
	for (int n = 0; n < 6; n++) begin
		build_random(48);
		run_program("random");
	end
	if (conflicts == 0) begin
		$display("fetch and data never requested the bus in the same cycle");
		abort_run();
	end else begin
		$display("%0d cycles with fetch and data requesting together", conflicts);
		$display("TB PASSED");
		$finish;
	end
end

endmodule : core_tb
